/* filelist.f */
hdl/fetch_pkg.sv
hdl/wait_timer.sv
hdl/pc_select.sv
hdl/fetch_fsm.sv
hdl/imem_rom.sv
hdl/fetch_ex_reg.sv
hdl/fetch_top.sv
verification/tb_clk_gen.sv
verification/fetch_tb.sv

/* hdl/fetch_ex_reg.sv */
// Fetch/execute pipeline register with valid/ready toward execute
// Flush clears the entry and beats a load in the same cycle
// An item with an exception stays valid but carries a zero instruction
// ex_valid and the payload hold until ex_valid && ex_ready
`timescale 1ns/1ps
`default_nettype none

module fetch_ex_reg (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             load,
    input  logic             flush,
    input  fetch_pkg::word_t load_instr,
    input  fetch_pkg::word_t load_pc,
    input  fetch_pkg::exc_e  load_exc,
    input  logic             ex_ready,
    output logic             full,
    output logic             ex_take,
    output logic             ex_valid,
    output fetch_pkg::word_t ex_instr,
    output fetch_pkg::word_t ex_pc,
    output fetch_pkg::word_t ex_pc4,
    output fetch_pkg::word_t ex_badaddr,
    output fetch_pkg::exc_e  ex_exc
);
    import fetch_pkg::*;

    logic  valid;
    word_t instr_q;
    word_t pc_q;
    word_t pc4_q;
    word_t badaddr_q;
    exc_e  exc_q;
    logic  has_exc;

    assign has_exc = (load_exc != EXC_NONE);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= 1'b1;              // Refill in the same cycle as a take
        end else if (ex_take) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (load && !flush) begin
            instr_q   <= has_exc ? '0 : load_instr;   // Squash to zero on exception
            pc_q      <= load_pc;
            pc4_q     <= load_pc + 32'd4;
            exc_q     <= load_exc;
            badaddr_q <= has_exc ? load_pc : '0;
        end
    end

    assign full       = valid;
    assign ex_take    = valid && ex_ready;
    assign ex_valid   = valid;
    assign ex_instr   = instr_q;
    assign ex_pc      = pc_q;
    assign ex_pc4     = pc4_q;
    assign ex_badaddr = badaddr_q;
    assign ex_exc     = exc_q;

endmodule

`default_nettype wire

/* hdl/fetch_fsm.sv */
// Fetch FSM driving the instruction bus
// One read in flight at most; ren stays high until the data cycle
// A redirect in any state drops the read in flight and restarts at ST_REQ
// A misaligned PC skips the bus and is loaded as EXC_MISALIGNED
`timescale 1ns/1ps
`default_nettype none

module fetch_fsm (
    input  logic             CLK,
    input  logic             nRST,
    input  fetch_pkg::word_t pc,
    input  logic             redirect,
    input  logic             full,
    input  logic             ex_take,
    input  logic             busy,
    input  logic             error,
    input  fetch_pkg::word_t rdata,
    output logic             ren,
    output fetch_pkg::word_t addr,
    output logic             pc_en,
    output logic             load,
    output fetch_pkg::word_t load_instr,
    output fetch_pkg::word_t load_pc,
    output fetch_pkg::exc_e  load_exc
);
    import fetch_pkg::*;

    fetch_state_e state;
    fetch_state_e next_state;
    logic         active;       // Low for the first cycle out of reset
    logic         misaligned;
    logic         slot_free;
    word_t        bus_instr;
    exc_e         bus_exc;
    word_t        hold_instr;
    exc_e         hold_exc;

    assign misaligned = (pc[1:0] != 2'b00);
    assign slot_free  = !full || ex_take;     // Register empty or draining this cycle
    assign addr       = pc;
    assign load_pc    = pc;                   // PC only advances with the load

    // Bus error becomes an access fault with the word squashed
    assign bus_instr = error ? '0 : rdata;
    assign bus_exc   = error ? EXC_FAULT : EXC_NONE;

    always_comb begin
        next_state = state;
        ren        = 1'b0;
        load       = 1'b0;
        load_instr = bus_instr;
        load_exc   = bus_exc;
        case (state)
            ST_REQ: begin
                if (misaligned) begin
                    load_instr = '0;
                    load_exc   = EXC_MISALIGNED;
                    load       = active && slot_free;
                end else begin
                    ren = active;
                    if (active && !busy) next_state = ST_WAIT;  // Read starts now
                end
            end
            ST_WAIT: begin
                ren = busy;
                if (!busy) begin                                // Data cycle
                    if (slot_free) begin
                        load       = 1'b1;
                        next_state = ST_REQ;
                    end else begin
                        next_state = ST_HOLD;
                    end
                end
            end
            ST_HOLD: begin
                load_instr = hold_instr;
                load_exc   = hold_exc;
                if (slot_free) begin
                    load       = 1'b1;
                    next_state = ST_REQ;
                end
            end
            default: next_state = ST_REQ;
        endcase

        // Redirect overrides everything, the pending data cycle is ignored
        if (redirect) begin
            next_state = ST_REQ;
            ren        = 1'b0;
            load       = 1'b0;
        end
    end

    assign pc_en = load;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state  <= ST_REQ;
            active <= 1'b0;
        end else begin
            state  <= next_state;
            active <= 1'b1;
        end
    end

    // Park the fetched word while execute is stalled
    always_ff @(posedge CLK) begin
        if (state == ST_WAIT && !busy) begin
            hold_instr <= bus_instr;
            hold_exc   <= bus_exc;
        end
    end

endmodule

`default_nettype wire

/* hdl/fetch_pkg.sv */
// Shared types and constants for the instruction fetch subsystem
// The ROM is word addressed in host order, so no endianness swap happens
// IMEM_WAIT must fit in the 2-bit count of the wait timer
// IMEM_FILE is opened relative to the simulator's working directory
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] word_t;

    // Fetch starts here after reset
    localparam word_t RESET_PC = 32'h0000_0000;

    // Instruction memory geometry and timing
    localparam int IMEM_WORDS = 32;              // Byte addresses 0..127 are valid
    localparam logic [1:0] IMEM_WAIT = 2'd2;     // Busy cycles before each read returns
    localparam string IMEM_FILE = "hdl/imem.hex";

    // Fetch FSM states
    typedef enum logic [1:0] {
        ST_REQ  = 2'd0,     // Present PC, start a read or tag a misaligned PC
        ST_WAIT = 2'd1,     // Read in flight, waiting for the data cycle
        ST_HOLD = 2'd2      // Word fetched, register full
    } fetch_state_e;

    // Exception cause carried with each fetched item
    typedef enum logic [1:0] {
        EXC_NONE       = 2'd0,
        EXC_MISALIGNED = 2'd1,
        EXC_FAULT      = 2'd2
    } exc_e;

endpackage

`default_nettype wire

/* hdl/fetch_top.sv */
// Instruction fetch subsystem top level
// Trap and branch redirects are single-cycle pulses, always accepted
// Latency to ex_valid varies with ROM wait states and back-pressure
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             trap_valid,
    input  logic             branch_valid,
    input  logic             ex_ready,
    input  fetch_pkg::word_t trap_pc,
    input  fetch_pkg::word_t branch_pc,
    output logic             ex_valid,
    output fetch_pkg::word_t ex_instr,
    output fetch_pkg::word_t ex_pc,
    output fetch_pkg::word_t ex_pc4,
    output fetch_pkg::word_t ex_badaddr,
    output fetch_pkg::exc_e  ex_exc
);
    import fetch_pkg::*;

    word_t pc;
    logic  redirect;
    logic  pc_en;
    logic  ren;
    word_t addr;
    logic  busy;
    logic  error;
    word_t rdata;
    logic  load;
    word_t load_instr;
    word_t load_pc;
    exc_e  load_exc;
    logic  full;
    logic  ex_take;

    pc_select pc_select_i (
        .CLK          (CLK),
        .nRST         (nRST),
        .trap_valid   (trap_valid),
        .branch_valid (branch_valid),
        .trap_pc      (trap_pc),
        .branch_pc    (branch_pc),
        .pc_en        (pc_en),
        .pc           (pc),
        .redirect     (redirect)
    );

    fetch_fsm fetch_fsm_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .pc         (pc),
        .redirect   (redirect),
        .full       (full),
        .ex_take    (ex_take),
        .busy       (busy),
        .error      (error),
        .rdata      (rdata),
        .ren        (ren),
        .addr       (addr),
        .pc_en      (pc_en),
        .load       (load),
        .load_instr (load_instr),
        .load_pc    (load_pc),
        .load_exc   (load_exc)
    );

    imem_rom imem_rom_i (
        .CLK   (CLK),
        .nRST  (nRST),
        .ren   (ren),
        .addr  (addr),
        .busy  (busy),
        .error (error),
        .rdata (rdata)
    );

    // Flush is the redirect itself
    fetch_ex_reg fetch_ex_reg_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .load       (load),
        .flush      (redirect),
        .load_instr (load_instr),
        .load_pc    (load_pc),
        .load_exc   (load_exc),
        .ex_ready   (ex_ready),
        .full       (full),
        .ex_take    (ex_take),
        .ex_valid   (ex_valid),
        .ex_instr   (ex_instr),
        .ex_pc      (ex_pc),
        .ex_pc4     (ex_pc4),
        .ex_badaddr (ex_badaddr),
        .ex_exc     (ex_exc)
    );

endmodule

`default_nettype wire

/* hdl/imem.hex */
// One 32-bit instruction word per line, word address 0 to 31
00100093
00200113
002081b3
40110233
0041a2b3
00329313
0062c3b3
00736433
0083f4b3
00a00513
fff50513
00b02023
00002583
00b50663
fe051ae3
000016b7
12368693
00d6a023
0006a703
00e787b3
40f70833
0017d893
4017d913
0128e9b3
01397a33
00000a97
014a8ab3
008000ef
00000073
00100073
30200073
10500073

/* hdl/imem_rom.sv */
// Instruction ROM with a busy/error read bus
// A read starts when ren is high and busy is low; busy then holds IMEM_WAIT
// cycles and the next cycle with busy low is the data cycle
// Addresses at or past IMEM_WORDS*4 return zero with error set
// Contents come from IMEM_FILE, word addressed, host byte order
`timescale 1ns/1ps
`default_nettype none

module imem_rom (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             ren,
    input  fetch_pkg::word_t addr,
    output logic             busy,
    output logic             error,
    output fetch_pkg::word_t rdata
);
    import fetch_pkg::*;

    localparam int IDX_W = $clog2(IMEM_WORDS);

    word_t mem [IMEM_WORDS];
    word_t addr_q;
    logic  pending;         // A read was started and has not returned
    logic  start;
    logic  data_phase;
    logic  out_of_range;

    initial begin
        $readmemh(IMEM_FILE, mem);
    end

    assign start        = ren && !busy;
    assign data_phase   = pending && !busy;
    assign out_of_range = (addr_q >= word_t'(IMEM_WORDS * 4));

    wait_timer timer_i (
        .CLK     (CLK),
        .nRST    (nRST),
        .start   (start),
        .count   (IMEM_WAIT),
        .running (busy)
    );

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pending <= 1'b0;
        end else if (start) begin
            pending <= 1'b1;
        end else if (data_phase) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (start) addr_q <= addr;      // Address is sampled once per read
    end

    assign error = data_phase && out_of_range;
    assign rdata = (data_phase && !out_of_range) ? mem[addr_q[IDX_W+1:2]] : '0;

endmodule

`default_nettype wire

/* hdl/pc_select.sv */
// Fetch program counter with prioritized next-PC selection
// Priority is trap, then branch, then the sequential PC+4
// Redirect pulses are single cycle and always accepted
`timescale 1ns/1ps
`default_nettype none

module pc_select (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             trap_valid,
    input  logic             branch_valid,
    input  fetch_pkg::word_t trap_pc,
    input  fetch_pkg::word_t branch_pc,
    input  logic             pc_en,
    output fetch_pkg::word_t pc,
    output logic             redirect
);
    import fetch_pkg::*;

    word_t target;
    word_t pc_next;
    word_t pc_q;

    assign redirect = trap_valid || branch_valid;

    // Trap wins over a branch in the same cycle
    assign target = trap_valid ? trap_pc : branch_pc;

    always_comb begin
        pc_next = pc_q;
        if (redirect) begin
            pc_next = target;
        end else if (pc_en) begin
            pc_next = pc_q + 32'd4;     // Sequential step, no compressed support
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc = pc_q;

endmodule

`default_nettype wire

/* hdl/wait_timer.sv */
// Down-counter that sets the busy window of the instruction ROM
// start reloads the counter; running is high while it is non-zero
`timescale 1ns/1ps
`default_nettype none

module wait_timer (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       start,
    input  logic [1:0] count,
    output logic       running
);

    logic [1:0] cnt;

    assign running = (cnt != 2'd0);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cnt <= 2'd0;
        end else if (start) begin
            cnt <= count;               // A zero count gives no busy cycles
        end else if (running) begin
            cnt <= cnt - 2'd1;
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the fetch testbench with Verilator from the project root
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --top-module fetch_tb \
    -f filelist.f --Mdir obj_dir -o fetch_sim

./obj_dir/fetch_sim 2>&1 | tee "$LOG"

if grep -qF '** PASS **' "$LOG"; then
    exit 0
else
    exit 1
fi

/* verification/fetch_tb.sv */
// Testbench for the instruction fetch subsystem
// Reads the ROM image from IMEM_FILE, so it runs from the project root
// An expected-PC model follows resets, transfers and redirects (trap over branch)
// Every accepted transfer is checked by concurrent assertions
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;
    import fetch_pkg::*;

    // 69 transfers over all tests at up to ~40 cycles each under stalls plus margin
    localparam int CYCLE_LIMIT = 4000;

    typedef enum logic [1:0] {READY_RANDOM, READY_STALLS, READY_HIGH} ready_mode_e;

    logic        CLK;
    logic        nRST;
    logic        trap_valid;
    logic        branch_valid;
    logic        ex_ready;
    word_t       trap_pc;
    word_t       branch_pc;
    logic        ex_valid;
    word_t       ex_instr;
    word_t       ex_pc;
    word_t       ex_pc4;
    word_t       ex_badaddr;
    exc_e        ex_exc;

    word_t       ref_mem [IMEM_WORDS];
    word_t       exp_pc;
    word_t       exp_instr;
    word_t       exp_badaddr;
    exc_e        exp_exc;
    logic        transfer;
    logic        redirect_in;
    ready_mode_e ready_mode;
    integer      seed = 32'h62d5f1ca;
    int          xfer_count;
    int          err_count = 0;
    int          cycle_count = 0;
    int          tests_done = 0;

    tb_clk_gen clk_gen_i (
        .CLK  (CLK),
        .nRST (nRST)
    );

    fetch_top dut_i (
        .CLK          (CLK),
        .nRST         (nRST),
        .trap_valid   (trap_valid),
        .branch_valid (branch_valid),
        .ex_ready     (ex_ready),
        .trap_pc      (trap_pc),
        .branch_pc    (branch_pc),
        .ex_valid     (ex_valid),
        .ex_instr     (ex_instr),
        .ex_pc        (ex_pc),
        .ex_pc4       (ex_pc4),
        .ex_badaddr   (ex_badaddr),
        .ex_exc       (ex_exc)
    );

    initial begin
        $readmemh(IMEM_FILE, ref_mem);
    end

    // Misaligned wins since such a PC never reaches the bus
    function automatic exc_e cause_for(input word_t pc);
        exc_e cause;
        cause = EXC_NONE;
        if (pc[1:0] != 2'b00) begin
            cause = EXC_MISALIGNED;
        end else if (pc >= word_t'(IMEM_WORDS * 4)) begin
            cause = EXC_FAULT;
        end
        return cause;
    endfunction

    assign transfer    = ex_valid && ex_ready;
    assign redirect_in = trap_valid || branch_valid;

    always_comb begin
        exp_exc     = cause_for(exp_pc);
        exp_instr   = (exp_exc == EXC_NONE) ? ref_mem[exp_pc[6:2]] : '0;
        exp_badaddr = (exp_exc == EXC_NONE) ? '0 : exp_pc;
    end

    // Expected-PC model
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            exp_pc     <= RESET_PC;
            xfer_count <= 0;
        end else begin
            if (trap_valid) begin
                exp_pc <= trap_pc;
            end else if (branch_valid) begin
                exp_pc <= branch_pc;
            end else if (transfer) begin
                exp_pc <= exp_pc + 32'd4;
            end
            if (transfer) xfer_count <= xfer_count + 1;
        end
    end

    always @(posedge CLK) cycle_count <= cycle_count + 1;

    task automatic report_mismatch(input string name, input word_t got, input word_t want);
        $display("MISMATCH %s got %h expected %h at cycle %0d", name, got, want, cycle_count);
        err_count = err_count + 1;
    endtask

    task automatic report_failure(input string what);
        $display("ERROR %s at cycle %0d", what, cycle_count);
        err_count = err_count + 1;
    endtask

    pc_check: assert property (@(posedge CLK) disable iff (!nRST) transfer |-> ex_pc == exp_pc)
        else report_mismatch("ex_pc", $sampled(ex_pc), $sampled(exp_pc));

    instr_check: assert property (@(posedge CLK) disable iff (!nRST)
        transfer |-> ex_instr == exp_instr)
        else report_mismatch("ex_instr", $sampled(ex_instr), $sampled(exp_instr));

    pc4_check: assert property (@(posedge CLK) disable iff (!nRST)
        transfer |-> ex_pc4 == exp_pc + 32'd4)
        else report_mismatch("ex_pc4", $sampled(ex_pc4), $sampled(exp_pc) + 32'd4);

    exc_check: assert property (@(posedge CLK) disable iff (!nRST) transfer |-> ex_exc == exp_exc)
        else report_mismatch("ex_exc", word_t'($sampled(ex_exc)), word_t'($sampled(exp_exc)));

    badaddr_check: assert property (@(posedge CLK) disable iff (!nRST)
        transfer |-> ex_badaddr == exp_badaddr)
        else report_mismatch("ex_badaddr", $sampled(ex_badaddr), $sampled(exp_badaddr));

    // Held item must not move or drop unless a redirect flushed it
    hold_check: assert property (@(posedge CLK) disable iff (!nRST)
        $past(ex_valid && !ex_ready && !redirect_in) |->
            ex_valid && $stable(ex_pc) && $stable(ex_pc4) && $stable(ex_instr)
            && $stable(ex_exc) && $stable(ex_badaddr))
        else report_failure("ex_valid or payload changed while ex_ready was low");

    reset_check: assert property (@(posedge CLK) $rose(nRST) |-> !ex_valid)
        else report_failure("ex_valid was high right after reset");

    // Drives ex_ready with long low stretches in stall mode
    initial begin : ready_driver
        int stall_left;
        stall_left = 0;
        ex_ready   = 1'b0;
        forever begin
            @(posedge CLK);
            if (ready_mode == READY_HIGH) begin
                ex_ready <= 1'b1;
            end else if (stall_left > 0) begin
                ex_ready   <= 1'b0;
                stall_left = stall_left - 1;
            end else if (ready_mode == READY_STALLS && (($random(seed) & 7) == 0)) begin
                stall_left = 4 + ($random(seed) & 15);
                ex_ready   <= 1'b0;
            end else begin
                ex_ready <= (($random(seed) & 1) != 0);
            end
        end
    end

    task automatic wait_transfers(input int n);
        int target;
        target = xfer_count + n;
        while (xfer_count < target) @(posedge CLK);
    endtask

    task automatic pulse_branch(input word_t target);
        @(posedge CLK);
        branch_valid <= 1'b1;
        branch_pc    <= target;
        @(posedge CLK);
        branch_valid <= 1'b0;
    endtask

    task automatic pulse_trap_and_branch(input word_t trap_target, input word_t branch_target);
        @(posedge CLK);
        trap_valid   <= 1'b1;
        trap_pc      <= trap_target;
        branch_valid <= 1'b1;
        branch_pc    <= branch_target;
        @(posedge CLK);
        trap_valid   <= 1'b0;
        branch_valid <= 1'b0;
    endtask

    task automatic report_test(input int num, input string name, input int xfer_start,
                               input int err_start);
        $display("test %0d %s: %0d transfers, %0d errors", num, name,
                 xfer_count - xfer_start, err_count - err_start);
        tests_done = tests_done + 1;
    endtask

    initial begin : main
        int xfer_mark;
        int err_mark;
        trap_valid   = 1'b0;
        branch_valid = 1'b0;
        trap_pc      = '0;
        branch_pc    = '0;
        ready_mode   = READY_RANDOM;
        @(posedge nRST);

        xfer_mark = xfer_count;
        err_mark  = err_count;
        wait_transfers(20);
        report_test(1, "sequential fetch", xfer_mark, err_mark);

        xfer_mark  = xfer_count;
        err_mark   = err_count;
        ready_mode <= READY_STALLS;
        wait_transfers(30);                         // Runs past the ROM end into faults
        report_test(2, "back-pressure", xfer_mark, err_mark);

        xfer_mark  = xfer_count;
        err_mark   = err_count;
        ready_mode <= READY_RANDOM;
        pulse_branch(32'h0000_0040);
        wait_transfers(6);
        report_test(3, "branch redirect", xfer_mark, err_mark);

        xfer_mark = xfer_count;
        err_mark  = err_count;
        pulse_trap_and_branch(32'h0000_0010, 32'h0000_0060);
        wait_transfers(6);
        report_test(4, "trap priority", xfer_mark, err_mark);

        xfer_mark = xfer_count;
        err_mark  = err_count;
        pulse_branch(32'h0000_0022);
        wait_transfers(4);
        report_test(5, "misaligned redirect", xfer_mark, err_mark);

        xfer_mark  = xfer_count;
        err_mark   = err_count;
        ready_mode <= READY_HIGH;
        pulse_branch(32'd124);
        wait_transfers(3);                          // 124 then faults at 128 and 132
        report_test(6, "access fault", xfer_mark, err_mark);

        $display("tests %0d, transfers %0d, errors %0d", tests_done, xfer_count, err_count);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycle_count < CYCLE_LIMIT) @(posedge CLK);
        $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/tb_clk_gen.sv */
// Clock and reset source for the fetch testbench
// 20 ns clock period, nRST held low for the first 5 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic CLK,
    output logic nRST
);

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 5;

    initial begin
        CLK = 1'b0;
        forever #HALF_PERIOD CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;       // Released on a rising edge
    end

endmodule

`default_nettype wire
